//--- src/lcd_pkg.sv
package lcd_pkg;

    // Pins of the 8-bit parallel LCD bus
    typedef struct packed {
        logic       en;
        logic       rw;
        logic       rs;
        logic [7:0] data;
    } lcd_bus_t;

    // Set DDRAM address command, bit 7 set plus the target address
    typedef struct packed {
        logic       set_addr;
        logic [6:0] addr;
    } ddram_addr_t;

    // One bus byte, read either as an address command or as a character code
    typedef union packed {
        ddram_addr_t addr_cmd;
        logic [7:0]  ascii;
    } lcd_byte_u;

    localparam logic [7:0] CMD_FUNCTION_SET = 8'h38; // 8-bit bus, 2 lines, 5x7
    localparam logic [7:0] CMD_DISP_OFF     = 8'h08;
    localparam logic [7:0] CMD_CLEAR        = 8'h01;
    localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06; // Increment, no shift
    localparam logic [7:0] CMD_DISP_ON      = 8'h0C; // Cursor off

    localparam logic [6:0] ROW1_BASE = 7'h00;
    localparam logic [6:0] ROW2_BASE = 7'h40;

    // Power-up wait, in LCD steps
    localparam int INIT_DELAY_STEPS = 10;

endpackage

//--- src/disp_pkg.sv
package disp_pkg;

    localparam int NUM_FIELDS  = 4;
    localparam int FIELD_CHARS = 6;
    localparam int ROW_CHARS   = 16;

    typedef logic [7:0]  char_t;
    typedef logic [15:0] field_word_t;

    // Ascending ranges put character 0 in the top byte
    typedef char_t [0:FIELD_CHARS-1] field_chars_t;
    typedef char_t [0:ROW_CHARS-1]   row_t;

    typedef struct packed {
        field_word_t value;
        logic        loaded;
    } held_field_t;

    localparam char_t CHAR_SPACE = 8'h20;
    localparam char_t CHAR_COLON = 8'h3A;
    localparam char_t CHAR_DASH  = 8'h2D;

    // Field shown for a word that was never loaded, e.g. "2:----"
    function automatic field_chars_t blank_field(input int unsigned idx);
        return {char_t'(8'h30 + idx), CHAR_COLON, {4{CHAR_DASH}}};
    endfunction

endpackage

//--- src/field_latch.sv
`timescale 1ns/10ps

module field_latch
    import disp_pkg::*;
(
    input  logic                           clk,
    input  logic                           nrst,
    input  field_word_t [NUM_FIELDS-1:0]   field_in,
    input  logic        [NUM_FIELDS-1:0]   load,
    output held_field_t [NUM_FIELDS-1:0]   held
);

    field_word_t [NUM_FIELDS-1:0] value_q;
    logic        [NUM_FIELDS-1:0] loaded_q;

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            if (load[i]) begin
                value_q[i] <= field_in[i];
            end
        end
    end

    // Flags decide between digits and dashes downstream
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            loaded_q <= '0;
        end else begin
            loaded_q <= loaded_q | load;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            held[i].value  = value_q[i];
            held[i].loaded = loaded_q[i];
        end
    end

    // An X strobe would leave the display in an undefined state
    assert property (@(posedge clk) disable iff (!nrst) !$isunknown(load))
        else $error("field_latch: load strobe unknown");

endmodule

//--- src/hex_field_fmt.sv
`timescale 1ns/10ps

module hex_field_fmt
    import disp_pkg::*;
#(
    parameter int unsigned label = 0
)(
    input  logic         clk,
    input  logic         nrst,
    input  held_field_t  field,
    output field_chars_t chars
);

    field_chars_t next_chars;

    function automatic char_t hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? char_t'(8'h30 + nib) : char_t'(8'h37 + nib); // Upper case
    endfunction

    function automatic logic nibble_ok(input char_t c);
        return (c >= 8'h30 && c <= 8'h39) || (c >= 8'h41 && c <= 8'h46) || (c == CHAR_DASH);
    endfunction

    always_comb begin
        next_chars = blank_field(label);
        if (field.loaded) begin
            for (int i = 0; i < 4; i++) begin
                next_chars[2 + i] = hex_char(field.value[15 - 4*i -: 4]); // MS nibble first
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            chars <= blank_field(label);
        end else begin
            chars <= next_chars;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst)
        nibble_ok(chars[2]) && nibble_ok(chars[3]) && nibble_ok(chars[4]) && nibble_ok(chars[5]))
        else $error("hex_field_fmt: bad digit character in field %0d", label);

endmodule

//--- src/row_assembler.sv
`timescale 1ns/10ps

module row_assembler
    import disp_pkg::*;
(
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            frame_start,
    input  field_chars_t [NUM_FIELDS-1:0]   fields,
    output row_t                            row_1,
    output row_t                            row_2
);

    // Two fields per row, each followed by two spaces
    function automatic row_t pack_row(input field_chars_t first, input field_chars_t second);
        return {first, CHAR_SPACE, CHAR_SPACE, second, CHAR_SPACE, CHAR_SPACE};
    endfunction

    localparam row_t ROW1_RESET = pack_row(blank_field(0), blank_field(1));
    localparam row_t ROW2_RESET = pack_row(blank_field(2), blank_field(3));

    row_t row_1_next;
    row_t row_2_next;

    always_comb begin
        row_1_next = pack_row(fields[0], fields[1]);
        row_2_next = pack_row(fields[2], fields[3]);
    end

    // Snapshot once per frame so the sequencer never sends a mix of old and new
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            row_1 <= ROW1_RESET;
            row_2 <= ROW2_RESET;
        end else if (frame_start) begin
            row_1 <= row_1_next;
            row_2 <= row_2_next;
        end
    end

endmodule

//--- src/lcd1602.sv
`timescale 1ns/10ps

module lcd1602
    import lcd_pkg::*;
    import disp_pkg::*;
#(
    parameter int clk_div = 24000
)(
    input  logic     clk,
    input  logic     nrst,
    input  row_t     row_1,
    input  row_t     row_2,
    output logic     frame_start,
    output lcd_bus_t lcd
);

    localparam int DELAY_CYCLES = INIT_DELAY_STEPS * clk_div;
    localparam int DELAY_W      = $clog2(DELAY_CYCLES);
    localparam int STEP_W       = $clog2(clk_div);

    localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(DELAY_CYCLES - 1);
    localparam logic [STEP_W-1:0]  STEP_LAST  = STEP_W'(clk_div - 1);
    localparam logic [STEP_W-1:0]  HALF_LAST  = STEP_W'(clk_div / 2 - 1);
    localparam logic [2:0]         INIT_LAST  = 3'd4;

    typedef enum logic [1:0] {
        PH_DELAY,
        PH_INIT,
        PH_ADDR,
        PH_CHAR
    } phase_t;

    phase_t             phase;
    logic [DELAY_W-1:0] delay_cnt;
    logic [STEP_W-1:0]  step_cnt;
    logic [2:0]         init_idx;
    logic [3:0]         col;
    logic               row_sel;   // 0 for row 1, 1 for row 2
    logic               en_q;
    logic               rs_q;
    logic [7:0]         data_q;

    phase_t     nxt_phase;
    logic [2:0] nxt_init;
    logic [3:0] nxt_col;
    logic       nxt_row_sel;
    logic       nxt_rs;
    logic [7:0] nxt_byte;
    logic       load_step;
    logic       delay_done;
    logic       step_end;
    row_t       cur_row;

    function automatic logic [7:0] init_cmd(input logic [2:0] idx);
        case (idx)
            3'd0:    return CMD_FUNCTION_SET;
            3'd1:    return CMD_DISP_OFF;
            3'd2:    return CMD_CLEAR;
            3'd3:    return CMD_ENTRY_MODE;
            default: return CMD_DISP_ON;
        endcase
    endfunction

    function automatic logic [7:0] addr_byte(input logic [6:0] base);
        lcd_byte_u b;
        b.addr_cmd.set_addr = 1'b1;
        b.addr_cmd.addr     = base;
        return b;
    endfunction

    assign delay_done = (phase == PH_DELAY) && (delay_cnt == DELAY_LAST);
    assign step_end   = (phase != PH_DELAY) && (step_cnt == STEP_LAST);
    assign cur_row    = row_sel ? row_2 : row_1;

    always_comb begin
        nxt_phase   = phase;
        nxt_init    = init_idx;
        nxt_col     = col;
        nxt_row_sel = row_sel;
        nxt_rs      = rs_q;
        nxt_byte    = data_q;
        load_step   = 1'b0;
        case (phase)
            PH_DELAY: begin
                if (delay_done) begin
                    load_step = 1'b1;
                    nxt_phase = PH_INIT;
                    nxt_init  = 3'd0;
                    nxt_rs    = 1'b0;
                    nxt_byte  = init_cmd(3'd0);
                end
            end
            PH_INIT: begin
                if (step_end) begin
                    load_step = 1'b1;
                    nxt_rs    = 1'b0;
                    if (init_idx == INIT_LAST) begin
                        nxt_phase   = PH_ADDR;
                        nxt_row_sel = 1'b0;
                        nxt_byte    = addr_byte(ROW1_BASE);
                    end else begin
                        nxt_init = init_idx + 3'd1;
                        nxt_byte = init_cmd(init_idx + 3'd1);
                    end
                end
            end
            PH_ADDR: begin
                if (step_end) begin
                    load_step = 1'b1;
                    nxt_phase = PH_CHAR;
                    nxt_col   = 4'd0;
                    nxt_rs    = 1'b1;
                    nxt_byte  = cur_row[0];
                end
            end
            default: begin
                if (step_end) begin
                    load_step = 1'b1;
                    if (col == 4'd15) begin
                        nxt_phase   = PH_ADDR;
                        nxt_row_sel = ~row_sel;
                        nxt_rs      = 1'b0;
                        nxt_byte    = addr_byte(row_sel ? ROW1_BASE : ROW2_BASE);
                    end else begin
                        nxt_col  = col + 4'd1;
                        nxt_byte = cur_row[col + 4'd1];
                    end
                end
            end
        endcase
    end

    // High in the cycle whose closing edge puts 0x80 on the bus
    assign frame_start = load_step && (nxt_phase == PH_ADDR) && !nxt_row_sel;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            delay_cnt <= '0;
        end else if (phase == PH_DELAY && !delay_done) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step_cnt <= '0;
        end else if (load_step) begin
            step_cnt <= '0;
        end else if (phase != PH_DELAY) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            en_q <= 1'b1;   // Held high through the power-up wait
        end else if (load_step) begin
            en_q <= 1'b1;
        end else if (phase != PH_DELAY && step_cnt == HALF_LAST) begin
            en_q <= 1'b0;   // LCD latches on this falling edge
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase    <= PH_DELAY;
            init_idx <= '0;
            col      <= '0;
            row_sel  <= 1'b0;
            rs_q     <= 1'b0;
            data_q   <= 8'h00;
        end else begin
            phase    <= nxt_phase;
            init_idx <= nxt_init;
            col      <= nxt_col;
            row_sel  <= nxt_row_sel;
            rs_q     <= nxt_rs;
            data_q   <= nxt_byte;
        end
    end

    always_comb begin
        lcd.en   = en_q;
        lcd.rw   = 1'b0;    // Write only
        lcd.rs   = rs_q;
        lcd.data = data_q;
    end

    assert property (@(posedge clk) disable iff (!nrst) !lcd.rw && !$isunknown(lcd))
        else $error("lcd1602: rw high or bus unknown");

    // Byte must not move while the LCD may be sampling it
    assert property (@(posedge clk) disable iff (!nrst)
        (lcd.en && $past(lcd.en) && $past(phase) != PH_DELAY) |-> $stable({lcd.rs, lcd.data}))
        else $error("lcd1602: rs/data changed while en high");

endmodule

//--- src/lcd_status_top.sv
`timescale 1ns/10ps

module lcd_status_top
    import disp_pkg::*;
    import lcd_pkg::*;
#(
    parameter int clk_div = 24000
)(
    input  logic                           clk,
    input  logic                           nrst,
    input  field_word_t [NUM_FIELDS-1:0]   field_in,
    input  logic        [NUM_FIELDS-1:0]   load,
    output lcd_bus_t                       lcd
);

    held_field_t  [NUM_FIELDS-1:0] held;
    field_chars_t [NUM_FIELDS-1:0] fields;
    row_t                          row_1;
    row_t                          row_2;
    logic                          frame_start;

    field_latch u_latch (
        .clk      (clk),
        .nrst     (nrst),
        .field_in (field_in),
        .load     (load),
        .held     (held)
    );

    for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_fmt
        hex_field_fmt #(
            .label (i)
        ) u_fmt (
            .clk   (clk),
            .nrst  (nrst),
            .field (held[i]),
            .chars (fields[i])
        );
    end

    row_assembler u_rows (
        .clk         (clk),
        .nrst        (nrst),
        .frame_start (frame_start),
        .fields      (fields),
        .row_1       (row_1),
        .row_2       (row_2)
    );

    lcd1602 #(
        .clk_div (clk_div)
    ) u_lcd (
        .clk         (clk),
        .nrst        (nrst),
        .row_1       (row_1),
        .row_2       (row_2),
        .frame_start (frame_start),
        .lcd         (lcd)
    );

endmodule

//--- sim/tb_lcd_status.sv
`timescale 1ns/10ps

module tb_lcd_status
    import lcd_pkg::*;
    import disp_pkg::*;
;

    localparam int CLK_DIV     = 8;
    localparam int TEST_FRAMES = 10;   // Frames read by all tests together
    localparam longint WATCHDOG_NS =
        2 * (longint'(TEST_FRAMES * 34 + 5 + INIT_DELAY_STEPS) * CLK_DIV * 40 + 3 * 40);

    logic                         clk;
    logic                         nrst;
    field_word_t [NUM_FIELDS-1:0] field_in;
    logic        [NUM_FIELDS-1:0] load;
    lcd_bus_t                     lcd;

    logic [8:0]  bus_q[$];             // {rs, data} per falling edge of en
    logic [8:0]  frame_buf[34];
    field_word_t model_val[NUM_FIELDS];
    logic        model_loaded[NUM_FIELDS];
    field_word_t new_val[NUM_FIELDS];
    logic [15:0] lfsr_state;
    int          errors;
    int          checks;

    lcd_status_top #(
        .clk_div (CLK_DIV)
    ) UUT (
        .clk      (clk),
        .nrst     (nrst),
        .field_in (field_in),
        .load     (load),
        .lcd      (lcd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // The LCD latches on the falling edge of en
    always @(negedge lcd.en) begin
        if (nrst) bus_q.push_back({lcd.rs, lcd.data});
    end

    always @(negedge clk) begin
        if (nrst) begin
            assert (lcd.rw == 1'b0) else begin
                errors++;
                $display("ERR %0t: rw expected 0, got %0b", $time, lcd.rw);
            end
        end
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic field_word_t rand_word();
        field_word_t w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        return w;
    endfunction

    // Character at one column of one row, from the display layout
    function automatic logic [7:0] exp_char(input int row, input int col);
        string      hex_digits;
        int         fld;
        int         pos;
        logic [3:0] nib;
        hex_digits = "0123456789ABCDEF";
        fld = 2 * row + col / 8;
        pos = col % 8;
        if (pos >= 6) return 8'h20;
        if (pos == 0) return 8'(48 + fld);   // Label digit
        if (pos == 1) return 8'h3A;
        if (!model_loaded[fld]) return 8'h2D;
        nib = 4'(model_val[fld] >> (4 * (5 - pos)));
        return hex_digits[nib];
    endfunction

    task automatic check_byte(input string what, input int idx,
                              input logic [8:0] exp, input logic [8:0] got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t: %s byte %0d expected rs=%0b 0x%02h, got rs=%0b 0x%02h",
                     $time, what, idx, exp[8], exp[7:0], got[8], got[7:0]);
        end
    endtask

    task automatic pop_byte(output logic [8:0] b);
        while (bus_q.size() == 0) @(posedge clk);
        b = bus_q.pop_front();
    endtask

    task automatic collect(input int first, input int count);
        for (int i = first; i < first + count; i++) pop_byte(frame_buf[i]);
    endtask

    task automatic check_frame(input string what);
        logic [8:0] exp;
        for (int i = 0; i < 34; i++) begin
            if (i == 0) exp = {1'b0, 8'h80};
            else if (i == 17) exp = {1'b0, 8'hC0};
            else if (i < 17) exp = {1'b1, exp_char(0, i - 1)};
            else exp = {1'b1, exp_char(1, i - 18)};
            check_byte(what, i, exp, frame_buf[i]);
        end
    endtask

    task automatic load_fields(input logic [NUM_FIELDS-1:0] mask);
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_FIELDS; i++) field_in[i] = new_val[i];
        load = mask;
        @(posedge clk);
        #2;
        load = '0;
    endtask

    task automatic commit_model(input logic [NUM_FIELDS-1:0] mask);
        for (int i = 0; i < NUM_FIELDS; i++) begin
            if (mask[i]) begin
                model_val[i]    = new_val[i];
                model_loaded[i] = 1'b1;
            end
        end
    endtask

    task automatic init_test();
        logic [7:0] cmds[5];
        logic [8:0] got;
        cmds = '{8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};
        for (int i = 0; i < 5; i++) begin
            pop_byte(got);
            check_byte("init", i, {1'b0, cmds[i]}, got);
        end
    endtask

    task automatic reset_view_test();
        collect(0, 34);
        check_frame("reset view");
    endtask

    task automatic load_format_test();
        for (int i = 0; i < NUM_FIELDS; i++) new_val[i] = rand_word();
        load_fields('1);
        commit_model('1);
        collect(0, 34);                      // Frame in progress may hold either
        collect(0, 34);
        check_frame("load and format");
    endtask

    task automatic coherency_test();
        for (int i = 0; i < NUM_FIELDS; i++) new_val[i] = rand_word();
        collect(0, 5);                       // Address and first row 1 characters
        load_fields('1);
        collect(5, 29);
        check_frame("coherency old");
        commit_model('1);
        collect(0, 34);
        check_frame("coherency new");
    endtask

    task automatic single_field_test();
        // Fields without a strobe still see new words on field_in
        for (int i = 0; i < NUM_FIELDS; i++) new_val[i] = rand_word();
        new_val[2][15:14] = 2'b11;           // Top digit in C..F
        load_fields(4'b0100);
        commit_model(4'b0100);
        collect(0, 34);
        collect(0, 34);
        check_frame("single field");
    endtask

    task automatic cadence_test();
        lcd_byte_u  b;
        logic [6:0] base;
        for (int f = 0; f < 3; f++) begin
            collect(0, 34);
            for (int i = 0; i < 34; i++) begin
                b = frame_buf[i][7:0];
                if (i % 17 == 0) begin
                    base = (i == 0) ? 7'h00 : 7'h40;
                    checks++;
                    assert (!frame_buf[i][8] && b.addr_cmd.set_addr && b.addr_cmd.addr == base)
                    else begin
                        errors++;
                        $display("ERR %0t: frame %0d byte %0d expected address 0x%02h, got %s",
                                 $time, f, i, base,
                                 $sformatf("rs=%0b 0x%02h", frame_buf[i][8], b.ascii));
                    end
                end else begin
                    check_byte("cadence", i, {1'b1, exp_char(i / 17, i % 17 - 1)},
                               {frame_buf[i][8], b.ascii});
                end
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the LCD bus stopped short of the expected bytes after %0d ns",
                 WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        nrst       = 1'b0;
        load       = '0;
        field_in   = '0;
        lfsr_state = 16'd21959;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < NUM_FIELDS; i++) begin
            model_val[i]    = '0;
            model_loaded[i] = 1'b0;
            new_val[i]      = '0;
        end
        repeat (3) @(posedge clk);
        #2 nrst = 1'b1;

        init_test();
        reset_view_test();
        load_format_test();
        coherency_test();
        single_field_test();
        cadence_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- lcd_status.f
src/lcd_pkg.sv
src/disp_pkg.sv
src/field_latch.sv
src/hex_field_fmt.sv
src/row_assembler.sv
src/lcd1602.sv
src/lcd_status_top.sv
sim/tb_lcd_status.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lcd_status
FILELIST  ?= lcd_status.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
